// File: Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_csr_stats
FILELIST  = project.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   list these targets"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: include/tb_csr_checks.svh
// MMIO bus drivers and typed response checks for the statistics block testbench
`ifndef TB_CSR_CHECKS_SVH
`define TB_CSR_CHECKS_SVH

// ============================================================
// Compare tasks
// ============================================================

// Read response payload
task automatic check_data(input string name, input t_mmio_data got,
                          input t_mmio_data exp);
    if (got !== exp)
    begin
        $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
        stop_run("Read data did not match the expected counter value");
    end
endtask

// Transaction ID returned with a response
task automatic check_tid(input string name, input t_mmio_tid got,
                         input t_mmio_tid exp);
    if (got !== exp)
    begin
        $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
        stop_run("Response ID did not match the request");
    end
endtask

// ============================================================
// Bus drivers
// ============================================================

// Host address of a CSR word in 4-byte units
function automatic t_mmio_addr word_addr(input int w_idx);
    return t_mmio_addr'(CSR_BASE_ADDR / 4 + 2 * w_idx);
endfunction

// One clock of stimulus; the event totals follow what is driven
task automatic drive_cycle(input logic [NUM_STATS-1:0] ev, input logic rd,
                           input t_mmio_addr addr, input t_mmio_tid tid);
    @(posedge clk);
    events <= ev;
    mmio_rd_valid <= rd;
    mmio_rd_addr <= addr;
    mmio_rd_tid <= tid;
    for (int i = 0; i < NUM_STATS; i++)
    begin
        totals[i] = totals[i] + t_csr_word'(ev[i]);
    end
endtask

task automatic drive_idle(input int cycles);
    repeat (cycles)
    begin
        drive_cycle('0, 1'b0, '0, '0);
    end
endtask

// Single-cycle read strobe
task automatic send_read(input t_mmio_addr addr, input t_mmio_tid tid);
    drive_cycle('0, 1'b1, addr, tid);
endtask

// Pops the oldest captured response, waiting a bounded time for it
task automatic wait_response(output t_mmio_data data, output t_mmio_tid tid);
    int waited;

    waited = 0;
    while ((rsp_data_q.size() == 0) && (waited < RSP_WAIT_CYCLES))
    begin
        @(negedge clk);
        waited++;
    end

    if (rsp_data_q.size() == 0)
    begin
        stop_run($sformatf("No read response arrived within %0d cycles", RSP_WAIT_CYCLES));
    end
    else
    begin
        data = rsp_data_q.pop_front();
        tid = rsp_tid_q.pop_front();
    end
endtask

// Read one word and compare both ID and data
task automatic read_expect(input t_mmio_addr addr, input t_mmio_tid tid,
                           input t_mmio_data exp);
    t_mmio_data data;
    t_mmio_tid tid_got;

    send_read(addr, tid);
    drive_idle(1);
    wait_response(data, tid_got);
    check_tid("mmio_rsp_tid", tid_got, tid);
    check_data("mmio_rsp_data", data, exp);
endtask

`endif

// File: dv/tb_csr_stats.sv
// Directed testbench for the statistics counter block over its MMIO read port
`timescale 1ns/10ps

module tb_csr_stats;

    import csr_map_pkg::*;
    import mmio_pkg::*;

    // ============================================================
    // Run limits
    // ============================================================

    localparam int FLUSH_CYCLES = 1 << FLUSH_INTERVAL_LOG2;

    // Long enough for the last events to reach memory
    localparam int SETTLE_CYCLES = 2 * FLUSH_CYCLES + 16;

    // Worst case for one read with a full queue ahead of it
    localparam int RSP_WAIT_CYCLES = 4 + 6 * MMIO_MAX_INFLIGHT + 6;

    localparam int RANDOM_CYCLES = 4 * FLUSH_CYCLES;

    // All tests need about three thousand cycles
    localparam int TIMEOUT_CYCLES = 20000;

    logic clk;
    logic reset;
    logic mmio_rd_valid;
    t_mmio_addr mmio_rd_addr;
    t_mmio_tid mmio_rd_tid;
    logic [NUM_STATS-1:0] events;
    logic mmio_rsp_valid;
    t_mmio_tid mmio_rsp_tid;
    t_mmio_data mmio_rsp_data;

    // Reference event totals
    t_csr_word totals [NUM_STATS];

    // Captured responses in arrival order
    t_mmio_data rsp_data_q [$];
    t_mmio_tid rsp_tid_q [$];

    logic [31:0] lcg_state;
    int cycle_cnt = 0;

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "Run stopped at the first failure");
    endtask

    // Numerical Recipes LCG step
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

`include "tb_csr_checks.svh"

    csr_stats_top i_csr_stats_top
    (
        .clk(clk),
        .reset(reset),
        .mmio_rd_valid(mmio_rd_valid),
        .mmio_rd_addr(mmio_rd_addr),
        .mmio_rd_tid(mmio_rd_tid),
        .events(events),
        .mmio_rsp_valid(mmio_rsp_valid),
        .mmio_rsp_tid(mmio_rsp_tid),
        .mmio_rsp_data(mmio_rsp_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial
    begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        stop_run($sformatf("Run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end

    // Responses sampled away from the driving edge
    always @(negedge clk)
    begin
        if (!reset && mmio_rsp_valid)
        begin
            rsp_data_q.push_back(mmio_rsp_data);
            rsp_tid_q.push_back(mmio_rsp_tid);
        end
    end

    // ============================================================
    // Directed tests
    // ============================================================

    // Quiet outputs and cleared counters after reset
    task automatic test_reset_state();
        drive_idle(20);
        if (rsp_data_q.size() != 0)
        begin
            stop_run("A response strobe appeared with no read issued");
        end
        for (int i = 0; i < NUM_STATS; i++)
        begin
            read_expect(word_addr(STAT_BASE_IDX + i), t_mmio_tid'(next_random()), '0);
        end
    endtask

    // Different count per event then all events together
    task automatic test_directed_counts();
        for (int i = 0; i < NUM_STATS; i++)
        begin
            repeat ((i + 1) * 5 + 3)
            begin
                drive_cycle(NUM_STATS'(1 << i), 1'b0, '0, '0);
            end
        end
        repeat (7)
        begin
            drive_cycle('1, 1'b0, '0, '0);
        end
        drive_idle(SETTLE_CYCLES);
        for (int i = 0; i < NUM_STATS; i++)
        begin
            read_expect(word_addr(STAT_BASE_IDX + i), t_mmio_tid'(9'h040 + i), totals[i]);
        end
    endtask

    // Back to back reads over the whole region
    task automatic test_burst_all();
        t_mmio_data data;
        t_mmio_tid tid_got;
        t_mmio_data exp;

        for (int w = 0; w < NUM_CSR_WORDS; w++)
        begin
            send_read(word_addr(w), t_mmio_tid'(9'h100 + w));
        end
        drive_idle(1);
        for (int w = 0; w < NUM_CSR_WORDS; w++)
        begin
            wait_response(data, tid_got);
            check_tid("mmio_rsp_tid", tid_got, t_mmio_tid'(9'h100 + w));
            // Only the counter words hold anything
            exp = '0;
            if ((w >= STAT_BASE_IDX) && (w < STAT_BASE_IDX + NUM_STATS))
            begin
                exp = totals[w - STAT_BASE_IDX];
            end
            check_data("mmio_rsp_data", data, exp);
        end
    endtask

    // Reads just outside the region are dropped
    task automatic test_out_of_range();
        send_read(word_addr(0) - 16'd1, 9'h1f0);
        send_read(word_addr(NUM_CSR_WORDS), 9'h1f1);
        drive_idle(200);
        if (rsp_data_q.size() != 0)
        begin
            stop_run("An out-of-range read received a response");
        end
        read_expect(word_addr(STAT_BASE_IDX), 9'h1f2, totals[0]);
    endtask

    // Random events with counter reads spread through the traffic
    task automatic test_random_traffic();
        logic [31:0] r;
        logic rd;
        int k;
        t_mmio_tid tid;
        t_mmio_data data;
        t_mmio_tid tid_got;
        t_csr_word bound;
        int idx_q [$];
        t_mmio_tid tid_q [$];
        t_csr_word bound_q [$];

        for (int c = 0; c < RANDOM_CYCLES; c++)
        begin
            r = next_random();
            rd = (c % 16) == 0;
            k = (c / 16) % NUM_STATS;
            tid = t_mmio_tid'(r >> 8);
            drive_cycle(r[NUM_STATS-1:0], rd, word_addr(STAT_BASE_IDX + k), tid);
            if (rd)
            begin
                idx_q.push_back(k);
                tid_q.push_back(tid);
                bound_q.push_back(totals[k]);
            end
        end
        drive_idle(SETTLE_CYCLES);

        // Mid-run values never pass the total driven up to their strobe
        while (idx_q.size() > 0)
        begin
            k = idx_q.pop_front();
            bound = bound_q.pop_front();
            wait_response(data, tid_got);
            check_tid("mmio_rsp_tid", tid_got, tid_q.pop_front());
            if (data > bound)
            begin
                $display("Error: mmio_rsp_data 0x%h above event total 0x%h", data, bound);
                stop_run("A counter ran ahead of the events driven");
            end
        end

        for (int i = 0; i < NUM_STATS; i++)
        begin
            read_expect(word_addr(STAT_BASE_IDX + i), t_mmio_tid'(next_random()), totals[i]);
        end
    endtask

    // ============================================================
    // Main sequence
    // ============================================================

    initial
    begin
        reset = 1'b1;
        mmio_rd_valid = 1'b0;
        mmio_rd_addr = '0;
        mmio_rd_tid = '0;
        events = '0;
        lcg_state = 32'hf93f_0206;
        for (int i = 0; i < NUM_STATS; i++)
        begin
            totals[i] = '0;
        end

        repeat (10) @(posedge clk);
        reset <= 1'b0;

        test_reset_state();
        test_directed_counts();
        test_burst_all();
        test_out_of_range();
        test_random_traffic();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: hdl/csr_map_pkg.sv
// CSR word map, statistics counter layout and flush timing for the stats block
package csr_map_pkg;

    // ============================================================
    // CSR region geometry
    // ============================================================

    // Region size in 64-bit words
    localparam int NUM_CSR_WORDS = 16;

    // Byte address of word 0 in host MMIO space
    localparam int CSR_BASE_ADDR = 256;

    // Index of one 64-bit word inside the region
    typedef logic [$clog2(NUM_CSR_WORDS)-1:0] t_csr_idx;

    // One full CSR word as held in memory
    typedef logic [63:0] t_csr_word;

    // ============================================================
    // Statistics counters
    // ============================================================

    // Number of event inputs
    localparam int NUM_STATS = 4;

    // Counter i is stored at word STAT_BASE_IDX + i
    localparam int STAT_BASE_IDX = 8;

    // Local accumulator width
    localparam int STAT_CNT_WIDTH = 16;

    typedef logic [STAT_CNT_WIDTH-1:0] t_stat_cnt;

    // Accumulators for all events, entry i for event i
    typedef t_stat_cnt [NUM_STATS-1:0] t_stat_cnt_vec;

    // Flush period is 2**FLUSH_INTERVAL_LOG2 cycles
    localparam int FLUSH_INTERVAL_LOG2 = 8;

endpackage

// File: hdl/csr_read_engine.sv
// CSR word memory serving host reads and read-modify-write counter updates
`timescale 1ns/10ps

module csr_read_engine
(
    input  logic clk,
    input  logic reset,
    input  logic req_valid,
    input  csr_map_pkg::t_csr_idx req_idx,
    input  mmio_pkg::t_mmio_tid req_tid,
    input  logic upd_en,
    input  csr_map_pkg::t_stat_cnt_vec upd_counts,
    output logic req_deq,
    output logic upd_rdy,
    output logic mmio_rsp_valid,
    output mmio_pkg::t_mmio_tid mmio_rsp_tid,
    output mmio_pkg::t_mmio_data mmio_rsp_data
);

    import csr_map_pkg::*;
    import mmio_pkg::*;

    typedef enum logic [2:0]
    {
        ST_IDLE,
        ST_PROCESS,
        ST_READ,
        ST_ADD,
        ST_WRITEBACK
    } t_upd_state;

    t_upd_state upd_state;
    t_stat_cnt_vec upd_cnts;
    logic [$clog2(NUM_STATS)-1:0] stat_sel;
    t_csr_idx stat_idx;
    t_csr_word upd_sum;

    logic upd_busy;
    logic host_start;
    logic cnt_start;

    t_csr_word mem [NUM_CSR_WORDS];
    logic mem_rd_en;
    t_csr_idx mem_rd_idx;
    t_csr_word mem_rd_data;
    logic mem_wr_en;

    logic host_rd_q;
    t_mmio_tid host_tid_q;

    // ============================================================
    // Port arbitration
    // ============================================================

    // Memory port is owned by an update from its read to its writeback
    assign upd_busy = (upd_state == ST_READ) || (upd_state == ST_ADD) ||
                      (upd_state == ST_WRITEBACK);

    // Host reads go first whenever the port is free
    assign host_start = req_valid && !upd_busy;
    assign cnt_start = (upd_state == ST_PROCESS) && !req_valid;
    assign req_deq = host_start;

    assign stat_idx = t_csr_idx'(STAT_BASE_IDX) + t_csr_idx'(stat_sel);

    assign mem_rd_en = host_start || cnt_start;
    assign mem_rd_idx = host_start ? req_idx : stat_idx;
    assign mem_wr_en = (upd_state == ST_WRITEBACK);

    // ============================================================
    // Word memory
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < NUM_CSR_WORDS; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (mem_wr_en)
        begin
            mem[stat_idx] <= upd_sum;
        end
    end

    // Registered read port
    always_ff @(posedge clk)
    begin
        if (mem_rd_en)
        begin
            mem_rd_data <= mem[mem_rd_idx];
        end
    end

    // Host response, memory stage then output register
    always_ff @(posedge clk)
    begin
        host_rd_q <= host_start;
        host_tid_q <= req_tid;
        mmio_rsp_valid <= host_rd_q;
        mmio_rsp_tid <= host_tid_q;
        mmio_rsp_data <= mem_rd_data;

        if (reset)
        begin
            host_rd_q <= 1'b0;
            mmio_rsp_valid <= 1'b0;
        end
    end

    // ============================================================
    // Counter update FSM
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            upd_state <= ST_IDLE;
            upd_rdy <= 1'b1;
            stat_sel <= '0;
        end
        else
        begin
            case (upd_state)
                ST_IDLE:
                begin
                    if (upd_en)
                    begin
                        upd_state <= ST_PROCESS;
                        upd_rdy <= 1'b0;
                        stat_sel <= '0;
                    end
                end
                ST_PROCESS:
                begin
                    // Waits here while host reads are queued
                    if (cnt_start)
                    begin
                        upd_state <= ST_READ;
                    end
                end
                ST_READ:
                begin
                    upd_state <= ST_ADD;
                end
                ST_ADD:
                begin
                    upd_state <= ST_WRITEBACK;
                end
                ST_WRITEBACK:
                begin
                    stat_sel <= stat_sel + 1'b1;
                    if (int'(stat_sel) == NUM_STATS - 1)
                    begin
                        // Whole list written back
                        upd_state <= ST_IDLE;
                        upd_rdy <= 1'b1;
                    end
                    else
                    begin
                        upd_state <= ST_PROCESS;
                    end
                end
                default:
                begin
                    upd_state <= ST_IDLE;
                end
            endcase
        end
    end

    // Count vector shifts so entry 0 is always the counter in progress
    always_ff @(posedge clk)
    begin
        if ((upd_state == ST_IDLE) && upd_en)
        begin
            upd_cnts <= upd_counts;
        end
        else if (upd_state == ST_WRITEBACK)
        begin
            upd_cnts <= upd_cnts >> STAT_CNT_WIDTH;
        end

        // Read data sits in the port register since ST_READ
        if (upd_state == ST_ADD)
        begin
            upd_sum <= mem_rd_data + t_csr_word'(upd_cnts[0]);
        end
    end

    // An offered count vector must find the FSM idle
    assert property (@(posedge clk) disable iff (reset)
        upd_en |-> (upd_state == ST_IDLE));

endmodule

// File: hdl/csr_stats_top.sv
// Statistics counter block top joining accumulators, read queue and CSR engine
`timescale 1ns/10ps

module csr_stats_top
(
    input  logic clk,
    input  logic reset,
    input  logic mmio_rd_valid,
    input  mmio_pkg::t_mmio_addr mmio_rd_addr,
    input  mmio_pkg::t_mmio_tid mmio_rd_tid,
    input  logic [csr_map_pkg::NUM_STATS-1:0] events,
    output logic mmio_rsp_valid,
    output mmio_pkg::t_mmio_tid mmio_rsp_tid,
    output mmio_pkg::t_mmio_data mmio_rsp_data
);

    import csr_map_pkg::*;
    import mmio_pkg::*;

    // Flush handoff
    logic upd_rdy;
    logic upd_en;
    t_stat_cnt_vec upd_counts;

    // Queue head toward the engine
    logic req_valid;
    logic req_deq;
    t_csr_idx req_idx;
    t_mmio_tid req_tid;

    stat_accumulators i_stat_accumulators
    (
        .clk(clk),
        .reset(reset),
        .events(events),
        .upd_rdy(upd_rdy),
        .upd_en(upd_en),
        .upd_counts(upd_counts)
    );

    mmio_req_queue i_mmio_req_queue
    (
        .clk(clk),
        .reset(reset),
        .mmio_rd_valid(mmio_rd_valid),
        .mmio_rd_addr(mmio_rd_addr),
        .mmio_rd_tid(mmio_rd_tid),
        .req_deq(req_deq),
        .req_valid(req_valid),
        .req_idx(req_idx),
        .req_tid(req_tid)
    );

    csr_read_engine i_csr_read_engine
    (
        .clk(clk),
        .reset(reset),
        .req_valid(req_valid),
        .req_idx(req_idx),
        .req_tid(req_tid),
        .upd_en(upd_en),
        .upd_counts(upd_counts),
        .req_deq(req_deq),
        .upd_rdy(upd_rdy),
        .mmio_rsp_valid(mmio_rsp_valid),
        .mmio_rsp_tid(mmio_rsp_tid),
        .mmio_rsp_data(mmio_rsp_data)
    );

endmodule

// File: hdl/mmio_pkg.sv
// Host MMIO read request and response field types
package mmio_pkg;

    // Host address in 4-byte units
    typedef logic [15:0] t_mmio_addr;

    // Transaction ID returned with each response
    localparam int MMIO_TID_WIDTH = 9;

    typedef logic [MMIO_TID_WIDTH-1:0] t_mmio_tid;

    // Read response payload
    typedef logic [63:0] t_mmio_data;

    // Host limit on unanswered reads
    localparam int MMIO_MAX_INFLIGHT = 64;

endpackage

// File: hdl/mmio_req_queue.sv
// Host read request queue with CSR range filter and word index conversion
`timescale 1ns/10ps

module mmio_req_queue
#(
    parameter int DEPTH = mmio_pkg::MMIO_MAX_INFLIGHT
)
(
    input  logic clk,
    input  logic reset,
    input  logic mmio_rd_valid,
    input  mmio_pkg::t_mmio_addr mmio_rd_addr,
    input  mmio_pkg::t_mmio_tid mmio_rd_tid,
    input  logic req_deq,
    output logic req_valid,
    output csr_map_pkg::t_csr_idx req_idx,
    output mmio_pkg::t_mmio_tid req_tid
);

    import csr_map_pkg::*;
    import mmio_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Region bounds in 4-byte units
    localparam t_mmio_addr ADDR_FIRST = t_mmio_addr'(CSR_BASE_ADDR / 4);
    localparam t_mmio_addr ADDR_LAST = t_mmio_addr'((CSR_BASE_ADDR + NUM_CSR_WORDS * 8) / 4);

    // ============================================================
    // Input register and range filter
    // ============================================================

    logic rd_valid_q;
    t_mmio_addr rd_addr_q;
    t_mmio_tid rd_tid_q;

    always_ff @(posedge clk)
    begin
        rd_valid_q <= mmio_rd_valid;
        rd_addr_q <= mmio_rd_addr;
        rd_tid_q <= mmio_rd_tid;

        if (reset)
        begin
            rd_valid_q <= 1'b0;
        end
    end

    logic in_range;
    t_mmio_addr addr_off;

    assign in_range = (rd_addr_q >= ADDR_FIRST) && (rd_addr_q < ADDR_LAST);
    assign addr_off = rd_addr_q - ADDR_FIRST;

    // Enqueue stage
    logic enq_en;
    t_csr_idx enq_idx;
    t_mmio_tid enq_tid;

    always_ff @(posedge clk)
    begin
        // Out-of-range reads are dropped here
        enq_en <= rd_valid_q && in_range;
        // Two 4-byte units per 64-bit word
        enq_idx <= addr_off[1 +: $bits(t_csr_idx)];
        enq_tid <= rd_tid_q;

        if (reset)
        begin
            enq_en <= 1'b0;
        end
    end

    // ============================================================
    // Circular buffer behind a registered head
    // ============================================================

    t_csr_idx mem_idx [DEPTH];
    t_mmio_tid mem_tid [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] mem_cnt;
    logic mem_empty;
    logic head_load;
    logic mem_wr;
    logic mem_rd;
    logic full;

    assign mem_empty = (mem_cnt == '0);

    // Head register refills when empty or popped
    assign head_load = !req_valid || req_deq;

    // New entry skips the buffer when it goes straight to the head
    assign mem_wr = enq_en && !(head_load && mem_empty);
    assign mem_rd = req_deq && !mem_empty;

    // Occupancy counts the head too
    assign full = (mem_cnt + CNT_W'(req_valid)) == CNT_W'(DEPTH);

    always_ff @(posedge clk)
    begin
        if (mem_wr)
        begin
            mem_idx[wr_ptr] <= enq_idx;
            mem_tid[wr_ptr] <= enq_tid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            mem_cnt <= '0;
            req_valid <= 1'b0;
        end
        else
        begin
            if (mem_wr)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end

            if (mem_rd)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            mem_cnt <= mem_cnt + CNT_W'(mem_wr) - CNT_W'(mem_rd);

            if (head_load)
            begin
                req_valid <= enq_en || !mem_empty;
            end
        end
    end

    // Oldest stored entry wins over the incoming one
    always_ff @(posedge clk)
    begin
        if (head_load)
        begin
            req_idx <= mem_empty ? enq_idx : mem_idx[rd_ptr];
            req_tid <= mem_empty ? enq_tid : mem_tid[rd_ptr];
        end
    end

    // Host must stay within its outstanding read limit
    assert property (@(posedge clk) disable iff (reset) enq_en |-> !full);

    // Engine pops only a waiting request
    assert property (@(posedge clk) disable iff (reset) req_deq |-> req_valid);

endmodule

// File: hdl/stat_accumulators.sv
// Per-event accumulators with a periodic flush of their counts toward the CSR counters
`timescale 1ns/10ps

module stat_accumulators
(
    input  logic clk,
    input  logic reset,
    input  logic [csr_map_pkg::NUM_STATS-1:0] events,
    input  logic upd_rdy,
    output logic upd_en,
    output csr_map_pkg::t_stat_cnt_vec upd_counts
);

    import csr_map_pkg::*;

    // ============================================================
    // Flush timer
    // ============================================================

    // Top bit set means the interval has run out
    logic [FLUSH_INTERVAL_LOG2:0] flush_timer;
    logic flush_due;

    assign flush_due = flush_timer[FLUSH_INTERVAL_LOG2];

    // Hand over the counts as soon as the engine is idle
    assign upd_en = flush_due && upd_rdy;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            flush_timer <= '0;
        end
        else if (upd_en)
        begin
            // Next interval starts with the flush
            flush_timer <= '0;
        end
        else if (!flush_due)
        begin
            // Hold at expiry while an update list is still running
            flush_timer <= flush_timer + 1'b1;
        end
    end

    // ============================================================
    // Event accumulators
    // ============================================================

    logic [NUM_STATS-1:0] events_q;
    t_stat_cnt_vec acc;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            events_q <= '0;
            acc <= '0;
        end
        else
        begin
            // Events are registered before the add for timing
            events_q <= events;

            for (int i = 0; i < NUM_STATS; i++)
            begin
                // On a flush the old sum leaves on upd_counts
                // and the registered event seeds the new one
                acc[i] <= (upd_en ? t_stat_cnt'(0) : acc[i]) + t_stat_cnt'(events_q[i]);
            end
        end
    end

    assign upd_counts = acc;

    // Counts are only offered to an idle engine, which then takes them
    assert property (@(posedge clk) disable iff (reset)
        upd_en |-> upd_rdy ##1 !upd_rdy);

endmodule

// File: project.f
+incdir+include
hdl/csr_map_pkg.sv
hdl/mmio_pkg.sv
hdl/stat_accumulators.sv
hdl/mmio_req_queue.sv
hdl/csr_read_engine.sv
hdl/csr_stats_top.sv
dv/tb_csr_stats.sv
